/* build.f */
verilog/rob_pkg.sv
verilog/rob_pointers.sv
verilog/rob_flush_mask.sv
verilog/rob_entry_array.sv
verilog/rob_retire.sv
verilog/rob.sv
dv/rob_checker.sv
dv/tb_rob.sv

/* Bender.yml */
package:
  name: rob

sources:
  - verilog/rob_pkg.sv
  - verilog/rob_pointers.sv
  - verilog/rob_flush_mask.sv
  - verilog/rob_entry_array.sv
  - verilog/rob_retire.sv
  - verilog/rob.sv
  - target: test
    files:
      - dv/rob_checker.sv
      - dv/tb_rob.sv

/* dv/tb_rob.sv */
/*
 * Testbench for the re-order buffer. Drives random allocations, completions
 * and flushes in several phases; rob_checker compares the results.
 */

`timescale 1ns/1ns

module tb_rob import rob_pkg::*; ();

    localparam int run_cycles     = 2000;
    localparam int timeout_cycles = run_cycles + run_cycles / 4;

    logic                       clk;
    logic                       rst_n;
    alloc_req_t [1:0]           new_req;
    fu_update_t [fu_number-1:0] update;
    logic                       flush_valid;
    ticket_t                    flush_ticket;
    issue_status_t              status;
    commit_t                    commit_1;
    commit_t                    commit_2;

    int      checks;
    int      errors;
    int      tb_errors;
    int      cycle_count;
    integer  seed;
    logic    saw_full;

    // Tickets in allocation order, and those still waiting for a completion
    ticket_t inflight[$];
    ticket_t pending_q[$];

    always #20 clk = ~clk;

    rob u_rob (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_req      (new_req),
        .update       (update),
        .flush_valid  (flush_valid),
        .flush_ticket (flush_ticket),
        .status       (status),
        .commit_1     (commit_1),
        .commit_2     (commit_2)
    );

    rob_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_req      (new_req),
        .update       (update),
        .flush_valid  (flush_valid),
        .flush_ticket (flush_ticket),
        .status       (status),
        .commit_1     (commit_1),
        .commit_2     (commit_2),
        .checks       (checks),
        .errors       (errors)
    );

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic drop_pending(input ticket_t t);
        for (int i = pending_q.size() - 1; i >= 0; i--) begin
            if (pending_q[i] == t) begin
                pending_q.delete(i);
            end
        end
    endtask

    task automatic retire_oldest();
        ticket_t t;
        t = inflight.pop_front();
        drop_pending(t);
    endtask

    task automatic add_request(input int s, input ticket_t t);
        new_req[s].valid      = 1'b1;
        new_req[s].valid_dest = (pick(4) != 0);
        new_req[s].lreg       = lreg_bits'(pick(32));
        new_req[s].preg       = preg_bits'(pick(128));
        new_req[s].ppreg      = preg_bits'(pick(128));
        new_req[s].microop    = microop_bits'(pick(32));
        inflight.push_back(t);
        if (!flush_valid) begin
            pending_q.push_back(t);
        end
    endtask

    task automatic drive_cycle(input int alloc_pct, input int comp_pct, input int flush_pct);
        int      k;
        int      idx;
        int      allowed;
        logic    v0;
        logic    v1;
        ticket_t t;
        new_req      = '0;
        update       = '0;
        flush_valid  = 1'b0;
        flush_ticket = '0;
        if (status.is_full) begin
            saw_full = 1'b1;
        end
        // Entries on the commit ports leave at the next edge
        if (commit_1.valid_commit) begin
            retire_oldest();
        end
        if (commit_2.valid_commit) begin
            retire_oldest();
        end
        if (inflight.size() > 0 && pick(100) < flush_pct) begin
            k            = pick(inflight.size());
            flush_valid  = 1'b1;
            flush_ticket = inflight[k];
            // Younger entries never complete
            for (int i = k + 1; i < inflight.size(); i++) begin
                drop_pending(inflight[i]);
            end
        end
        for (int j = 0; j < fu_number; j++) begin
            if (pending_q.size() > 0 && pick(100) < comp_pct) begin
                idx                 = pick(pending_q.size());
                update[j].valid     = 1'b1;
                update[j].ticket    = pending_q[idx];
                update[j].exception = (pick(10) == 0);
                update[j].cause     = cause_bits'(pick(16));
                pending_q.delete(idx);
            end
        end
        allowed = status.is_full ? 0 : (status.two_free ? 2 : 1);
        v0      = (pick(100) < alloc_pct) && (allowed > 0);
        v1      = (pick(100) < alloc_pct) && (allowed > 0);
        if (allowed == 1 && v0 && v1) begin
            if (pick(2) == 0) begin
                v0 = 1'b0;
            end else begin
                v1 = 1'b0;
            end
        end
        t = status.ticket;
        if (v0) begin
            add_request(0, t);
            t = t + ticket_t'(1);
        end
        if (v1) begin
            add_request(1, t);
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input int alloc_pct,
                             input int comp_pct, input int flush_pct, input logic expect_full);
        int errors_before;
        errors_before = errors + tb_errors;
        saw_full      = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            drive_cycle(alloc_pct, comp_pct, flush_pct);
        end
        @(posedge clk);
        #1;
        if (expect_full && !saw_full) begin
            tb_errors++;
            $display("The buffer never reported full during test %s", name);
        end
        if (errors + tb_errors == errors_before) begin
            $display("Test %s: PASS", name);
        end else begin
            $display("Test %s: FAIL, %0d errors", name, errors + tb_errors - errors_before);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d clock cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        new_req      = '0;
        update       = '0;
        flush_valid  = 1'b0;
        flush_ticket = '0;
        seed         = 32'h0c45bd40;
        tb_errors    = 0;
        saw_full     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Phase lengths add up to run_cycles
        run_phase("alloc_order", 300, 70, 60, 0, 1'b0);
        run_phase("random_mix", 900, 60, 50, 3, 1'b0);
        run_phase("fill_to_full", 200, 90, 0, 0, 1'b1);
        run_phase("flush_heavy", 400, 70, 40, 15, 1'b0);
        run_phase("drain", 200, 0, 80, 0, 1'b0);

        $display("Closing counts: %0d checks, %0d errors", checks, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/rob_checker.sv */
/*
 * Reference model of the re-order buffer for the testbench.
 * Follows the DUT inputs and compares commits and status on every rising edge.
 */

`timescale 1ns/1ns

module rob_checker import rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  alloc_req_t [1:0]           new_req,
    input  fu_update_t [fu_number-1:0] update,
    input  logic                       flush_valid,
    input  ticket_t                    flush_ticket,
    input  issue_status_t              status,
    input  commit_t                    commit_1,
    input  commit_t                    commit_2,
    output int                         checks,
    output int                         errors
);

    typedef struct packed {
        ticket_t                 ticket;
        logic                    valid_dest;
        logic [lreg_bits-1:0]    lreg;
        logic [preg_bits-1:0]    preg;
        logic [preg_bits-1:0]    ppreg;
        logic                    pending;
        logic                    flushed;
        logic                    exception;
        logic [cause_bits-1:0]   cause;
    } model_entry_t;

    // Oldest entry at the front
    model_entry_t model_q[$];
    ticket_t      model_tail;

    function automatic commit_t expected_commit(model_entry_t e, logic retire);
        commit_t c;
        c = '0;
        c.valid_commit = retire;
        if (retire) begin
            c.valid_write = e.valid_dest && !e.flushed && !e.exception;
            c.flushed     = e.flushed;
            c.exception   = e.exception;
            c.cause       = e.cause;
            c.ldst        = e.valid_dest ? e.lreg : '0;
            c.pdst        = e.valid_dest ? e.preg : '0;
            c.ppdst       = e.valid_dest ? e.ppreg : '0;
            c.ticket      = e.ticket;
        end
        return c;
    endfunction

    task automatic compare_commit(input string name, input commit_t exp, input commit_t act);
        logic mismatch;
        checks++;
        if (exp.valid_commit) begin
            mismatch = (act !== exp);
        end else begin
            // No retirement means no register file write either
            mismatch = (act.valid_commit !== 1'b0) || (act.valid_write !== 1'b0);
        end
        if (mismatch) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic apply_completions();
        model_entry_t e;
        for (int j = 0; j < fu_number; j++) begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (update[j].valid && model_q[i].ticket == update[j].ticket) begin
                    e           = model_q[i];
                    e.pending   = 1'b0;
                    e.exception = update[j].exception;
                    e.cause     = update[j].cause;
                    model_q[i]  = e;
                end
            end
        end
    endtask

    // Everything allocated after the flush ticket is marked
    task automatic apply_flush();
        int           k;
        model_entry_t e;
        k = -1;
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].ticket == flush_ticket) begin
                k = i;
            end
        end
        if (k < 0) begin
            errors++;
            $display("Flush at %0t ns names ticket %0d, which is not in flight", $time,
                     flush_ticket);
        end else begin
            for (int i = k + 1; i < model_q.size(); i++) begin
                e          = model_q[i];
                e.flushed  = 1'b1;
                model_q[i] = e;
            end
        end
    endtask

    task automatic push_request(input alloc_req_t req);
        model_entry_t e;
        e            = '0;
        e.ticket     = model_tail;
        e.valid_dest = req.valid_dest;
        e.lreg       = req.lreg;
        e.preg       = req.preg;
        e.ppreg      = req.ppreg;
        e.pending    = 1'b1;
        e.flushed    = flush_valid;
        model_q.push_back(e);
        model_tail = model_tail + ticket_t'(1);
    endtask

    always @(posedge clk or negedge rst_n) begin
        logic          retire_1;
        logic          retire_2;
        issue_status_t exp_status;
        if (!rst_n) begin
            model_q.delete();
            model_tail = '0;
            checks     = 0;
            errors     = 0;
        end else begin
            retire_1 = (model_q.size() > 0)
                     && (!model_q[0].pending || model_q[0].flushed);
            retire_2 = retire_1 && !model_q[0].exception && (model_q.size() > 1)
                     && (!model_q[1].pending || model_q[1].flushed)
                     && !model_q[1].exception;
            compare_commit("commit_1", expected_commit(model_q[0], retire_1), commit_1);
            compare_commit("commit_2", expected_commit(model_q[1], retire_2), commit_2);

            exp_status.ticket   = model_tail;
            exp_status.is_full  = (model_q.size() == rob_entries);
            exp_status.two_free = (model_q.size() <= rob_entries - 2);
            checks++;
            if (status !== exp_status) begin
                errors++;
                $display("** Error at %0t ns: status expected %h, got %h", $time,
                         exp_status, status);
            end

            // Advance the model only after the comparison
            apply_completions();
            if (flush_valid) begin
                apply_flush();
            end
            if (retire_1) begin
                void'(model_q.pop_front());
            end
            if (retire_2) begin
                void'(model_q.pop_front());
            end
            if (new_req[0].valid) begin
                push_request(new_req[0]);
            end
            if (new_req[1].valid) begin
                push_request(new_req[1]);
            end
            if (model_q.size() > rob_entries) begin
                errors++;
                $display("At %0t ns more than %0d entries were allocated", $time, rob_entries);
            end
        end
    end

endmodule

/* verilog/rob.sv */
/*
 * Re-order buffer for a dual-issue out-of-order core.
 * Allocates two entries and retires up to two per cycle in program order.
 */

`timescale 1ns/1ns

module rob import rob_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  alloc_req_t [1:0]           new_req,
    input  fu_update_t [fu_number-1:0] update,
    input  logic                       flush_valid,
    input  ticket_t                    flush_ticket,
    output issue_status_t              status,
    output commit_t                    commit_1,
    output commit_t                    commit_2
);

    ticket_t                      head;
    ticket_t                      tail;
    logic       [1:0]             retire_count;
    logic       [rob_entries-1:0] flush_mask;
    rob_entry_t [rob_entries-1:0] entries;

    rob_pointers u_pointers (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_req      (new_req),
        .retire_count (retire_count),
        .head         (head),
        .tail         (tail),
        .status       (status)
    );

    rob_flush_mask u_flush_mask (
        .flush_ticket (flush_ticket),
        .head         (head),
        .flush_mask   (flush_mask)
    );

    rob_entry_array u_entry_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .new_req      (new_req),
        .tail         (tail),
        .update       (update),
        .flush_valid  (flush_valid),
        .flush_mask   (flush_mask),
        .retire_count (retire_count),
        .head         (head),
        .entries      (entries)
    );

    // Sole source of the retirement decision
    rob_retire u_retire (
        .entries      (entries),
        .head         (head),
        .commit_1     (commit_1),
        .commit_2     (commit_2),
        .retire_count (retire_count)
    );

endmodule

/* verilog/rob_retire.sv */
/*
 * Retirement decision for the head and the entry after it.
 * Produces both commit records and the number of entries freed.
 */

`timescale 1ns/1ns

module rob_retire import rob_pkg::*; (
    input  rob_entry_t [rob_entries-1:0] entries,
    input  ticket_t                      head,
    output commit_t                      commit_1,
    output commit_t                      commit_2,
    output logic       [1:0]             retire_count
);

    ticket_t    head_plus;
    rob_entry_t first;
    rob_entry_t second;
    logic       retire_1;
    logic       retire_2;

    // Record for one retiring slot, destination fields zero without a destination
    function automatic commit_t make_commit(rob_entry_t e, logic retire, ticket_t ticket);
        commit_t c;
        c.valid_commit = retire;
        c.valid_write  = retire & e.valid_dest & ~e.flushed & ~e.exception;
        c.flushed      = e.flushed;
        c.exception    = e.exception;
        c.cause        = e.cause;
        c.ldst         = e.valid_dest ? e.lreg : '0;
        c.pdst         = e.valid_dest ? e.preg : '0;
        c.ppdst        = e.valid_dest ? e.ppreg : '0;
        c.ticket       = ticket;
        return c;
    endfunction

    assign head_plus = head + ticket_t'(1);
    assign first     = entries[head];
    assign second    = entries[head_plus];

    // Flushed entries leave even while still pending
    assign retire_1 = first.valid & (~first.pending | first.flushed);

    // Second slot only behind a clean head, and never with its own exception
    assign retire_2 = retire_1 & ~first.exception & second.valid
                    & (~second.pending | second.flushed) & ~second.exception;

    always_comb begin
        retire_count = 2'd0;
        if (retire_2) begin
            retire_count = 2'd2;
        end else if (retire_1) begin
            retire_count = 2'd1;
        end
    end

    assign commit_1 = make_commit(first, retire_1, head);
    assign commit_2 = make_commit(second, retire_2, head_plus);

endmodule

/* verilog/rob_entry_array.sv */
/*
 * Entry storage of the re-order buffer. Allocation writes at the tail,
 * completions clear pending, flushes mark entries and retirement frees them.
 */

`timescale 1ns/1ns

module rob_entry_array import rob_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n,
    input  alloc_req_t [1:0]             new_req,
    input  ticket_t                      tail,
    input  fu_update_t [fu_number-1:0]   update,
    input  logic                         flush_valid,
    input  logic       [rob_entries-1:0] flush_mask,
    input  logic       [1:0]             retire_count,
    input  ticket_t                      head,
    output rob_entry_t [rob_entries-1:0] entries
);

    rob_entry_t             slot_q [rob_entries];
    logic [rob_entries-1:0] valid_q;

    ticket_t    tail_plus;
    ticket_t    head_plus;
    logic       alloc_a_valid;
    logic       alloc_b_valid;
    alloc_req_t alloc_a_req;

    // Fresh entry as stored on allocation
    function automatic rob_entry_t make_entry(alloc_req_t req, logic flushed);
        rob_entry_t e;
        e.valid      = 1'b1;
        e.pending    = 1'b1;
        e.flushed    = flushed;
        e.valid_dest = req.valid_dest;
        e.lreg       = req.lreg;
        e.preg       = req.preg;
        e.ppreg      = req.ppreg;
        e.microop    = req.microop;
        e.exception  = 1'b0;
        e.cause      = '0;
        return e;
    endfunction

    assign tail_plus = tail + ticket_t'(1);
    assign head_plus = head + ticket_t'(1);

    // Slot a goes to the tail, slot b to tail+1 only when both are valid
    assign alloc_a_valid = new_req[0].valid | new_req[1].valid;
    assign alloc_b_valid = new_req[0].valid & new_req[1].valid;
    assign alloc_a_req   = new_req[0].valid ? new_req[0] : new_req[1];

    always_ff @(posedge clk) begin
        for (int i = 0; i < rob_entries; i++) begin
            if (alloc_a_valid && ticket_t'(i) == tail) begin
                slot_q[i] <= make_entry(alloc_a_req, flush_valid);
            end else if (alloc_b_valid && ticket_t'(i) == tail_plus) begin
                slot_q[i] <= make_entry(new_req[1], flush_valid);
            end else begin
                // Completions from the functional units
                for (int j = 0; j < fu_number; j++) begin
                    if (update[j].valid && update[j].ticket == ticket_t'(i)) begin
                        slot_q[i].pending   <= 1'b0;
                        slot_q[i].exception <= update[j].exception;
                        slot_q[i].cause     <= update[j].cause;
                    end
                end
                if (flush_valid && flush_mask[i]) begin
                    slot_q[i].flushed <= 1'b1;
                end
            end
        end
    end

    // Valid bits, set on allocation and cleared on retirement
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < rob_entries; i++) begin
                if (alloc_a_valid && ticket_t'(i) == tail) begin
                    valid_q[i] <= 1'b1;
                end else if (alloc_b_valid && ticket_t'(i) == tail_plus) begin
                    valid_q[i] <= 1'b1;
                end else if (retire_count != 2'd0 && ticket_t'(i) == head) begin
                    valid_q[i] <= 1'b0;
                end else if (retire_count == 2'd2 && ticket_t'(i) == head_plus) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rob_entries; i++) begin
            entries[i]       = slot_q[i];
            entries[i].valid = valid_q[i];
        end
    end

endmodule

/* verilog/rob_flush_mask.sv */
/*
 * Selects the slots younger than a flush ticket, wrapping around
 * the circular buffer until the head is reached.
 */

`timescale 1ns/1ns

module rob_flush_mask import rob_pkg::*; (
    input  ticket_t                flush_ticket,
    input  ticket_t                head,
    output logic [rob_entries-1:0] flush_mask
);

    always_comb begin
        ticket_t slot;
        logic    reached;
        flush_mask = '0;
        slot       = flush_ticket + ticket_t'(1);
        reached    = 1'b0;
        // Walk forward from the slot after the flush point
        for (int k = 0; k < rob_entries; k++) begin
            if (slot == head) begin
                reached = 1'b1;
            end
            if (!reached) begin
                flush_mask[slot] = 1'b1;
            end
            slot = slot + ticket_t'(1);
        end
    end

endmodule

/* verilog/rob_pointers.sv */
/*
 * Head, tail and occupancy registers of the re-order buffer.
 * Status for the issue stage comes from registered state only.
 */

`timescale 1ns/1ns

module rob_pointers import rob_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  alloc_req_t [1:0]    new_req,
    input  logic       [1:0]    retire_count,
    output ticket_t             head,
    output ticket_t             tail,
    output issue_status_t       status
);

    logic [count_bits-1:0] count;
    logic [count_bits-1:0] count_next;
    logic [1:0]            alloc_count;

    // Number of requests accepted this cycle
    always_comb begin
        alloc_count = 2'd0;
        if (new_req[0].valid && new_req[1].valid) begin
            alloc_count = 2'd2;
        end else if (new_req[0].valid || new_req[1].valid) begin
            alloc_count = 2'd1;
        end
    end

    assign count_next = count + count_bits'(alloc_count) - count_bits'(retire_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail <= '0;
        end else begin
            tail <= tail + ticket_t'(alloc_count);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
        end else begin
            head <= head + ticket_t'(retire_count);
        end
    end

    // Occupancy, allocations minus retirements
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count_next;
        end
    end

    // Issue side reads these before it drives requests
    always_comb begin
        status.ticket   = tail;
        status.is_full  = (count == count_bits'(rob_entries));
        status.two_free = (count <= count_bits'(rob_entries - 2));
    end

endmodule

/* verilog/rob_pkg.sv */
/*
 * Shared sizes, field widths and packed records of the re-order buffer.
 * Imported by every RTL block and by the testbench.
 */

package rob_pkg;

    // Buffer geometry
    localparam int rob_entries  = 8;
    localparam int ticket_bits  = 3;
    localparam int count_bits   = 4;
    localparam int fu_number    = 4;

    // Field widths
    localparam int lreg_bits    = 5;
    localparam int preg_bits    = 7;
    localparam int cause_bits   = 4;
    localparam int microop_bits = 5;

    typedef logic [ticket_bits-1:0] ticket_t;

    // One allocation request from the issue stage
    typedef struct packed {
        logic                    valid;
        logic                    valid_dest;
        logic [lreg_bits-1:0]    lreg;
        logic [preg_bits-1:0]    preg;
        logic [preg_bits-1:0]    ppreg;
        logic [microop_bits-1:0] microop;
    } alloc_req_t;

    // Completion from a functional unit
    typedef struct packed {
        logic                  valid;
        ticket_t               ticket;
        logic                  exception;
        logic [cause_bits-1:0] cause;
    } fu_update_t;

    typedef struct packed {
        logic                    valid;
        logic                    pending;
        logic                    flushed;
        logic                    valid_dest;
        logic [lreg_bits-1:0]    lreg;
        logic [preg_bits-1:0]    preg;
        logic [preg_bits-1:0]    ppreg;
        logic [microop_bits-1:0] microop;
        logic                    exception;
        logic [cause_bits-1:0]   cause;
    } rob_entry_t;

    typedef struct packed {
        ticket_t ticket;
        logic    is_full;
        logic    two_free;
    } issue_status_t;

    // Retirement record towards the architectural register file
    typedef struct packed {
        logic                  valid_commit;
        logic                  valid_write;
        logic                  flushed;
        logic                  exception;
        logic [cause_bits-1:0] cause;
        logic [lreg_bits-1:0]  ldst;
        logic [preg_bits-1:0]  pdst;
        logic [preg_bits-1:0]  ppdst;
        ticket_t               ticket;
    } commit_t;

endpackage
